// ==== warp_sched.f ====
logic/sched_cfg_pkg.sv
logic/sched_msg_pkg.sv
logic/warp_ctl_decode.sv
logic/barrier_table.sv
logic/warp_slot.sv
logic/warp_issue.sv
logic/warp_sched_top.sv
tests/sched_checker.sv
tests/warp_sched_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = warp_sched_tb
FILELIST = warp_sched.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS)' $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/warp_sched_tb.sv ====
// testbench for the warp scheduler, runs a table of control events and checks the issued warps
module warp_sched_tb;
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    typedef enum logic [2:0] {
        ev_none, ev_unlock, ev_tmc, ev_spawn, ev_branch, ev_bar
    } ev_kind_t;

    // one table row, the event and the issues it should cause
    typedef struct packed {
        ev_kind_t     kind;
        wid_t         wid;
        logic [31:0]  mask;
        pc_t          pc;
        logic         taken;
        logic         bp;
        logic         busy;
        int           n;
        issue_t [3:0] exp;
    } row_t;

    localparam pc_t start_pc = 32'h1000;
    localparam int  step     = 4;
    localparam pc_t spawn_pc = 32'h2000;
    localparam pc_t br_dest  = 32'h3000;

    logic      clk = 1'b0;
    logic      reset;
    warp_ctl_t ctl;
    branch_t   branch;
    logic      unlock_valid;
    wid_t      unlock_wid;
    logic      out_ready;
    logic      out_valid;
    issue_t    out;
    logic      busy;

    logic         exp_load;
    int           exp_count;
    issue_t [3:0] exp_list;
    logic         exp_busy;
    logic         row_end;
    int           chk_seen;
    int           chk_errors;

    row_t        rows[$];
    logic [31:0] rng = 32'ha884;

    always #2 clk = ~clk;

    warp_sched_top #(
        .start_pc (start_pc),
        .pc_step  (step)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out          (out),
        .busy         (busy)
    );

    sched_checker chk0 (
        .clk       (clk),
        .reset     (reset),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .busy      (busy),
        .exp_load  (exp_load),
        .exp_count (exp_count),
        .exp_list  (exp_list),
        .exp_busy  (exp_busy),
        .row_end   (row_end),
        .seen      (chk_seen),
        .errors    (chk_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic add_row(input ev_kind_t kind, input int wid, input int mask, input int pc,
                           input int taken, input int bp, input int busy_after);
        row_t r;
        r       = '0;
        r.kind  = kind;
        r.wid   = wid_t'(wid);
        r.mask  = mask;
        r.pc    = pc_t'(pc);
        r.taken = (taken != 0);
        r.bp    = (bp != 0);
        r.busy  = (busy_after != 0);
        rows.push_back(r);
    endtask

    task automatic add_exp(input int wid, input int pc, input int tmask);
        row_t   r;
        issue_t e;
        r       = rows[rows.size() - 1];
        e.wid   = wid_t'(wid);
        e.pc    = pc_t'(pc);
        e.tmask = tmask_t'(tmask);
        r.exp[r.n[1:0]] = e;
        r.n++;
        rows[rows.size() - 1] = r;
    endtask

    task automatic build_table();
        // startup, then nothing until an unlock
        add_row(ev_none, 0, 0, 0, 0, 0, 1);
        add_exp(0, start_pc, 1);
        add_row(ev_none, 0, 0, 0, 0, 0, 1);
        add_row(ev_unlock, 0, 0, 0, 0, 0, 1);
        add_exp(0, start_pc + step, 1);
        // warp 0 spawns 1 to 3, lowest ready first
        add_row(ev_spawn, 0, 'b1110, spawn_pc, 0, 0, 1);
        add_exp(0, start_pc + 2 * step, 1);
        add_exp(1, spawn_pc, 1);
        add_exp(2, spawn_pc, 1);
        add_exp(3, spawn_pc, 1);
        add_row(ev_unlock, 2, 0, 0, 0, 0, 1);
        add_exp(2, spawn_pc + step, 1);
        // taken, then not taken with a bogus dest
        add_row(ev_branch, 1, 0, br_dest, 1, 0, 1);
        add_exp(1, br_dest, 1);
        add_row(ev_branch, 3, 0, 'h5000, 0, 0, 1);
        add_exp(3, spawn_pc + step, 1);
        add_row(ev_tmc, 1, 'b1011, 0, 0, 0, 1);
        add_exp(1, br_dest + step, 'b1011);
        add_row(ev_unlock, 0, 0, 0, 0, 1, 1);
        add_exp(0, start_pc + 3 * step, 1);
        // barrier 1 with size_m1 of 2, third arrival releases
        add_row(ev_bar, 2, 0, 0, 0, 0, 1);
        add_row(ev_bar, 0, 0, 0, 0, 0, 1);
        add_row(ev_bar, 1, 0, 0, 0, 1, 1);
        add_exp(0, start_pc + 4 * step, 1);
        add_exp(1, br_dest + 2 * step, 'b1011);
        add_exp(2, spawn_pc + 2 * step, 1);
        // retire every warp
        add_row(ev_tmc, 3, 0, 0, 0, 0, 1);
        add_row(ev_tmc, 0, 0, 0, 0, 0, 1);
        add_row(ev_tmc, 1, 0, 0, 0, 0, 1);
        add_row(ev_tmc, 2, 0, 0, 0, 0, 0);
        add_row(ev_unlock, 3, 0, 0, 0, 0, 0);
    endtask

    task automatic clear_event();
        ctl          = '0;
        branch       = '0;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
    endtask

    task automatic drive_event(input row_t r);
        clear_event();
        case (r.kind)
            ev_unlock: begin
                unlock_valid = 1'b1;
                unlock_wid   = r.wid;
            end
            ev_tmc: begin
                ctl.valid     = 1'b1;
                ctl.wid       = r.wid;
                ctl.tmc_valid = 1'b1;
                ctl.tmc_mask  = tmask_t'(r.mask);
            end
            ev_spawn: begin
                ctl.valid       = 1'b1;
                ctl.wid         = r.wid;
                ctl.spawn_valid = 1'b1;
                ctl.spawn_mask  = warp_vec_t'(r.mask);
                ctl.spawn_pc    = r.pc;
            end
            ev_branch: begin
                branch.valid = 1'b1;
                branch.wid   = r.wid;
                branch.taken = r.taken;
                branch.dest  = r.pc;
            end
            ev_bar: begin
                ctl.valid       = 1'b1;
                ctl.wid         = r.wid;
                ctl.bar_valid   = 1'b1;
                ctl.bar_id      = bar_id_t'(1);
                ctl.bar_size_m1 = wid_t'(2);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        row_t     row;
        ev_kind_t kind;
        int       cycles;
        int       bp_len;
        int       err_before;
        int       rows_failed;
        rows_failed = 0;
        reset       = 1'b1;
        clear_event();
        out_ready = 1'b1;
        exp_load  = 1'b0;
        exp_count = 0;
        exp_list  = '0;
        exp_busy  = 1'b0;
        row_end   = 1'b0;
        build_table();

        // watchdog
        fork
            begin
                repeat (rows.size() * 40) @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", rows.size() * 40);
                $display("*** TEST FAILED ***");
                $finish;
            end
        join_none

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int r = 0; r < rows.size(); r++) begin
            row    = rows[r];
            bp_len = 0;
            if (row.bp) begin
                rng    = xorshift32(rng);
                bp_len = 3 + int'(rng % 32'd6);
            end
            err_before = chk_errors;
            drive_event(row);
            exp_load  = 1'b1;
            exp_count = row.n;
            exp_list  = row.exp;
            exp_busy  = row.busy;
            out_ready = (bp_len == 0);
            cycles    = 0;
            // first edge loads the checker, later ones count issues
            do begin
                @(posedge clk);
                #1;
                clear_event();
                exp_load  = 1'b0;
                cycles++;
                out_ready = (cycles >= bp_len);
            end while ((row.n == 0) ? (cycles < 12) : (chk_seen < row.n && cycles < 30));

            row_end = 1'b1;
            @(posedge clk);
            #1;
            row_end = 1'b0;
            kind    = row.kind;
            if (chk_errors == err_before) begin
                $display("row %0d %s: pass", r, kind.name());
            end else begin
                rows_failed++;
                $display("row %0d %s: fail", r, kind.name());
            end
        end

        $display("rows %0d, failed %0d, errors %0d", rows.size(), rows_failed, chk_errors);
        if (chk_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/sched_checker.sv ====
// testbench monitor for the warp scheduler, compares each output handshake with the expected row
module sched_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          out_valid,
    input  logic                          out_ready,
    input  sched_msg_pkg::issue_t         out,
    input  logic                          busy,
    input  logic                          exp_load,
    input  int                            exp_count,
    input  sched_msg_pkg::issue_t [3:0]   exp_list,
    input  logic                          exp_busy,
    input  logic                          row_end,
    output int                            seen,
    output int                            errors
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    issue_t [3:0] want;
    int           want_count;
    logic         stalled_prev;
    issue_t       held;
    logic [1:0]   idx;

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] got);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            seen         = 0;
            errors       = 0;
            want         = '0;
            want_count   = 0;
            stalled_prev = 1'b0;
            held         = '0;
        end else begin
            if (exp_load) begin
                want       = exp_list;
                want_count = exp_count;
                seen       = 0;
            end

            // record must sit still under back-pressure
            if (stalled_prev) begin
                if (!out_valid) begin
                    $display("error at %0t: out_valid dropped while out_ready was low", $time);
                    errors++;
                end else begin
                    compare_field("out (held)", 64'(held), 64'(out));
                end
            end

            if (out_valid && out_ready) begin
                if (seen >= want_count) begin
                    $display("error at %0t: unexpected issue of warp %0d at pc %h",
                             $time, out.wid, out.pc);
                    errors++;
                end else begin
                    idx = seen[1:0];
                    compare_field("out.wid", 64'(want[idx].wid), 64'(out.wid));
                    compare_field("out.pc", 64'(want[idx].pc), 64'(out.pc));
                    compare_field("out.tmask", 64'(want[idx].tmask), 64'(out.tmask));
                end
                seen++;
            end
            stalled_prev = out_valid && !out_ready;
            held         = out;

            if (row_end) begin
                if (seen < want_count) begin
                    $display("error at %0t: missing issue, expected %0d but saw %0d",
                             $time, want_count, seen);
                    errors++;
                end
                compare_field("busy", 64'(exp_busy), 64'(busy));
            end
        end
    end

endmodule

// ==== logic/warp_sched_top.sv ====
// warp scheduler top level, instantiate this with the core's control and branch inputs
module warp_sched_top #(
    parameter int                 num_threads = sched_cfg_pkg::num_threads,
    parameter int                 pc_bits     = sched_cfg_pkg::pc_bits,
    parameter logic [pc_bits-1:0] start_pc    = 'h1000,
    parameter int                 pc_step     = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  sched_msg_pkg::warp_ctl_t ctl,
    input  sched_msg_pkg::branch_t   branch,
    input  logic                     unlock_valid,
    input  sched_cfg_pkg::wid_t      unlock_wid,
    input  logic                     out_ready,
    output logic                     out_valid,
    output sched_msg_pkg::issue_t    out,
    output logic                     busy
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    slot_cmd_t  [num_warps-1:0] cmd;
    warp_view_t [num_warps-1:0] views;
    warp_vec_t                  select;
    warp_vec_t                  advance;
    warp_vec_t                  active_mask;
    warp_vec_t                  release_mask;
    pc_t                        next_pc;

    warp_ctl_decode ctl_dec (
        .ctl          (ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .release_mask (release_mask),
        .cmd          (cmd)
    );

    barrier_table bar_tab (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .active_mask  (active_mask),
        .release_mask (release_mask)
    );

    for (genvar w = 0; w < num_warps; w++) begin : g_slot
        warp_slot #(
            .num_threads (num_threads),
            .pc_bits     (pc_bits),
            .start_pc    (start_pc)
        ) slot (
            .clk      (clk),
            .reset    (reset),
            .is_first (1'(w == 0)),
            .cmd      (cmd[w]),
            .select   (select[w]),
            .advance  (advance[w]),
            .next_pc  (next_pc),
            .view     (views[w])
        );
    end

    warp_issue #(
        .pc_step (pc_step)
    ) issue (
        .clk         (clk),
        .reset       (reset),
        .views       (views),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out         (out),
        .select      (select),
        .advance     (advance),
        .next_pc     (next_pc),
        .active_mask (active_mask),
        .busy        (busy)
    );

endmodule

// ==== logic/warp_issue.sv ====
// picks the lowest ready warp into a one-entry issue register with a valid/ready output
module warp_issue #(
    parameter int pc_step = 4
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  sched_msg_pkg::warp_view_t [sched_cfg_pkg::num_warps-1:0] views,
    input  logic                                                 out_ready,
    output logic                                                 out_valid,
    output sched_msg_pkg::issue_t                                out,
    output sched_cfg_pkg::warp_vec_t                             select,
    output sched_cfg_pkg::warp_vec_t                             advance,
    output sched_cfg_pkg::pc_t                                   next_pc,
    output sched_cfg_pkg::warp_vec_t                             active_mask,
    output logic                                                 busy
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_vec_t ready_mask;
    wid_t      pick_wid;
    logic      pick_valid;
    logic      fire;
    logic      can_load;
    issue_t    pick;

    assign fire     = out_valid && out_ready;
    // register empty or draining this cycle
    assign can_load = !out_valid || out_ready;
    assign next_pc  = out.pc + pc_t'(pc_step);

    // priority search, lowest wid wins
    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int w = 0; w < num_warps; w++) begin
            ready_mask[w]  = views[w].ready;
            active_mask[w] = views[w].active;
        end
        for (int w = num_warps - 1; w >= 0; w--) begin
            if (ready_mask[w]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'(w);
            end
        end
    end

    always_comb begin
        select  = '0;
        advance = '0;
        if (can_load && pick_valid) begin
            select[pick_wid] = 1'b1;
        end
        if (fire) begin
            advance[out.wid] = 1'b1;
        end
        pick.wid   = pick_wid;
        pick.tmask = views[pick_wid].tmask;
        // same warp draining now, its slot pc is one step behind
        if (fire && pick_wid == out.wid) begin
            pick.pc = next_pc;
        end else begin
            pick.pc = views[pick_wid].pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            if (can_load) begin
                out_valid <= pick_valid;
            end
            busy <= (|active_mask) || out_valid;
        end
    end

    // payload holds under back-pressure
    always_ff @(posedge clk) begin
        if (can_load && pick_valid) begin
            out <= pick;
        end
    end

endmodule

// ==== logic/warp_slot.sv ====
// state of a single warp (active, stalled, thread mask, pc), one instance per warp
module warp_slot #(
    parameter int                 num_threads = sched_cfg_pkg::num_threads,
    parameter int                 pc_bits     = sched_cfg_pkg::pc_bits,
    parameter logic [pc_bits-1:0] start_pc    = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      is_first,
    input  sched_msg_pkg::slot_cmd_t  cmd,
    input  logic                      select,
    input  logic                      advance,
    input  sched_cfg_pkg::pc_t        next_pc,
    output sched_msg_pkg::warp_view_t view
);
    logic                   active;
    logic                   stalled;
    logic [num_threads-1:0] tmask;
    logic [pc_bits-1:0]     pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            // only warp 0 runs out of reset, with thread 0
            active  <= is_first;
            stalled <= 1'b0;
            tmask   <= is_first ? num_threads'(1) : '0;
            pc      <= start_pc;
        end else begin
            if (cmd.set_tmask) begin
                active <= cmd.activate;
                tmask  <= cmd.tmask;
            end
            // select beats unlock, the warp has just been issued again
            if (select) begin
                stalled <= 1'b1;
            end else if (cmd.unlock) begin
                stalled <= 1'b0;
            end
            if (advance) begin
                pc <= next_pc;
            end else if (cmd.set_pc) begin
                pc <= cmd.pc;
            end
        end
    end

    always_comb begin
        view.active = active;
        view.ready  = active && !stalled;
        view.tmask  = tmask;
        view.pc     = pc;
    end

endmodule

// ==== logic/barrier_table.sv ====
// local barrier bookkeeping, counts arrivals per barrier and releases the waiting warps
module barrier_table (
    input  logic                     clk,
    input  logic                     reset,
    input  sched_msg_pkg::warp_ctl_t ctl,
    input  sched_cfg_pkg::warp_vec_t active_mask,
    output sched_cfg_pkg::warp_vec_t release_mask
);
    import sched_cfg_pkg::*;

    wid_t      [num_barriers-1:0] counts;
    warp_vec_t [num_barriers-1:0] waiting;
    warp_vec_t                    caller_bit;
    logic                         arrive;
    logic                         last_arrival;

    always_comb begin
        caller_bit = '0;
        caller_bit[ctl.wid] = 1'b1;
        arrive = ctl.valid && ctl.bar_valid;
        // final arrival when the count already holds size_m1 warps
        last_arrival = arrive && (counts[ctl.bar_id] == ctl.bar_size_m1);
        release_mask = '0;
        if (last_arrival) begin
            release_mask = (waiting[ctl.bar_id] | caller_bit) & active_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            counts  <= '0;
            waiting <= '0;
        end else if (last_arrival) begin
            counts[ctl.bar_id]  <= '0;
            waiting[ctl.bar_id] <= '0;
        end else if (arrive) begin
            // caller parks here, stall stays set
            counts[ctl.bar_id]  <= counts[ctl.bar_id] + wid_t'(1);
            waiting[ctl.bar_id] <= waiting[ctl.bar_id] | caller_bit;
        end
    end

endmodule

// ==== logic/warp_ctl_decode.sv ====
// merges control events, branch results and barrier releases into one command per warp slot
module warp_ctl_decode (
    input  sched_msg_pkg::warp_ctl_t                            ctl,
    input  sched_msg_pkg::branch_t                              branch,
    input  logic                                                unlock_valid,
    input  sched_cfg_pkg::wid_t                                 unlock_wid,
    input  sched_cfg_pkg::warp_vec_t                            release_mask,
    output sched_msg_pkg::slot_cmd_t [sched_cfg_pkg::num_warps-1:0] cmd
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            cmd[w] = '0;

            // barrier release and plain decode unlock
            if (release_mask[w]) begin
                cmd[w].unlock = 1'b1;
            end
            if (unlock_valid && unlock_wid == wid_t'(w)) begin
                cmd[w].unlock = 1'b1;
            end

            // events that name this warp as the caller
            if (ctl.valid && ctl.wid == wid_t'(w)) begin
                if (ctl.tmc_valid) begin
                    cmd[w].unlock    = 1'b1;
                    cmd[w].set_tmask = 1'b1;
                    cmd[w].tmask     = ctl.tmc_mask;
                    // zero mask retires the warp
                    cmd[w].activate  = |ctl.tmc_mask;
                end
                if (ctl.spawn_valid) begin
                    cmd[w].unlock = 1'b1;
                end
            end

            // spawned warps start with thread 0 only
            if (ctl.valid && ctl.spawn_valid && ctl.spawn_mask[w]) begin
                cmd[w].set_tmask = 1'b1;
                cmd[w].activate  = 1'b1;
                cmd[w].tmask     = tmask_t'(1);
                cmd[w].set_pc    = 1'b1;
                cmd[w].pc        = ctl.spawn_pc;
            end

            if (branch.valid && branch.wid == wid_t'(w)) begin
                cmd[w].unlock = 1'b1;
                if (branch.taken) begin
                    cmd[w].set_pc = 1'b1;
                    cmd[w].pc     = branch.dest;
                end
            end
        end
    end

endmodule

// ==== logic/sched_msg_pkg.sv ====
// record layouts exchanged between the scheduler blocks and with the pipeline around it
package sched_msg_pkg;

    import sched_cfg_pkg::*;

    // warp control event from the execute stage, one caller per cycle
    typedef struct packed {
        logic      valid;
        wid_t      wid;
        logic      tmc_valid;
        tmask_t    tmc_mask;
        logic      spawn_valid;
        warp_vec_t spawn_mask;
        pc_t       spawn_pc;
        logic      bar_valid;
        bar_id_t   bar_id;
        wid_t      bar_size_m1;
    } warp_ctl_t;

    // branch resolution
    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    // merged per-warp command for one cycle
    typedef struct packed {
        logic   unlock;
        logic   activate;
        logic   set_tmask;
        tmask_t tmask;
        logic   set_pc;
        pc_t    pc;
    } slot_cmd_t;

    // what a warp slot shows the issue stage
    typedef struct packed {
        logic   active;
        logic   ready;
        tmask_t tmask;
        pc_t    pc;
    } warp_view_t;

    typedef struct packed {
        wid_t   wid;
        pc_t    pc;
        tmask_t tmask;
    } issue_t;

endpackage

// ==== logic/sched_cfg_pkg.sv ====
// sizes, widths and vector types of the warp scheduler, imported by the RTL and the testbench
package sched_cfg_pkg;

    // core geometry
    parameter int num_warps    = 4;
    parameter int num_threads  = 4;
    parameter int num_barriers = 2;
    parameter int pc_bits      = 32;

    // index widths, never below one bit
    localparam int wid_bits = (num_warps > 1) ? $clog2(num_warps) : 1;
    localparam int bar_bits = (num_barriers > 1) ? $clog2(num_barriers) : 1;

    typedef logic [wid_bits-1:0]    wid_t;
    typedef logic [num_threads-1:0] tmask_t;
    typedef logic [pc_bits-1:0]     pc_t;
    typedef logic [num_warps-1:0]   warp_vec_t;
    typedef logic [bar_bits-1:0]    bar_id_t;

endpackage
